//--- dv/linegen_checker.sv
`include "linegen_config.svh"

module linegen_checker #(
	parameter int PTR_W = $clog2(`LINEGEN_BRAM_DELAY + 1)
) (
	input logic                     clk,
	input logic                     rst_gen_mode,
	input logic                     generator_mode,
	input linegen_pkg::bram_state_t bram_state,
	input logic [PTR_W-1:0]         els_in_buff,
	input logic                     next,
	input logic                     valid_line_out,
	input logic                     write_rdy
);

	localparam int BUFF_LEN = `LINEGEN_BRAM_DELAY + 1;

	// Host side owns the memory in write mode
	no_valid_in_write: assert property (@(posedge clk) disable iff (rst_gen_mode)
		bram_state == linegen_pkg::WRITE_MODE |-> !valid_line_out)
		else $error("valid_line_out high while in WRITE_MODE");

	occupancy_bounded: assert property (@(posedge clk) disable iff (rst_gen_mode)
		els_in_buff <= PTR_W'(BUFF_LEN))
		else $error("prefetch buffer occupancy above its length");

	// Lines are only handed out while replaying
	next_only_in_replay: assert property (@(posedge clk) disable iff (rst_gen_mode)
		next |-> (bram_state == linegen_pkg::GENERATOR_MODE ||
			bram_state == linegen_pkg::SIMPLE_MODE))
		else $error("next pulsed outside a replay state");

	write_rdy_follows_mode: assert property (@(posedge clk) disable iff (rst_gen_mode)
		(write_rdy != $past(write_rdy)) |-> (write_rdy == !$past(generator_mode)))
		else $error("write_rdy moved against generator_mode");

endmodule

bind bram_interface linegen_checker u_checker (
	.clk            (clk),
	.rst_gen_mode   (rst_gen_mode),
	.generator_mode (generator_mode),
	.bram_state     (bram_state),
	.els_in_buff    (els_in_buff),
	.next           (next),
	.valid_line_out (valid_line_out),
	.write_rdy      (write_rdy)
);

//--- dv/linegen_tb.sv
`include "linegen_config.svh"

module linegen_tb;

	localparam int WORD_W = `LINEGEN_WORD_WIDTH;
	localparam int WORDS = `LINEGEN_DATA_WIDTH / `LINEGEN_WORD_WIDTH;
	localparam int BUFF_LEN = `LINEGEN_BRAM_DELAY + 1;
	localparam int FILL_WAIT = 3 * (`LINEGEN_BRAM_DELAY + BUFF_LEN + 3);
	localparam int NUM_ROWS = 5;
	localparam int MAX_LINES = 16;

	// Per row the lines written, words replayed, restart word (-1 none), drop after,
	// trailing partial words and expected streaming mode
	int row_lines [NUM_ROWS] = '{3, 9, 9, 4, 7};
	int row_words [NUM_ROWS] = '{30, 60, 45, 30, 36};
	int row_restart [NUM_ROWS] = '{-1, -1, 20, 7, -1};
	int row_drop [NUM_ROWS] = '{1, 1, 1, 1, 0};
	int row_partial [NUM_ROWS] = '{0, 2, 1, 0, 2};
	int row_gen [NUM_ROWS] = '{0, 1, 1, 0, 1};

	logic clk;
	logic rst_gen_mode;
	linegen_pkg::word_t word_in;
	logic word_in_valid;
	logic generator_mode;
	logic replay_restart;
	logic word_take;
	linegen_pkg::word_t word_out;
	logic word_valid;
	logic write_rdy;

	linegen_pkg::line_t model [MAX_LINES];
	int errors;
	int row_errors;
	int checks;
	int cycle_count;
	int cycle_limit;

	linegen_top dut0 (
		.clk            (clk),
		.rst_gen_mode   (rst_gen_mode),
		.word_in        (word_in),
		.word_in_valid  (word_in_valid),
		.generator_mode (generator_mode),
		.replay_restart (replay_restart),
		.word_take      (word_take),
		.word_out       (word_out),
		.word_valid     (word_valid),
		.write_rdy      (write_rdy)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic write_session(input int n, input int partial);
		for (int i = 0; i < n; i++) begin
			model[i] = linegen_pkg::line_t'({$urandom, $urandom});
			for (int w = 0; w < WORDS; w++) begin
				word_in = model[i][w*WORD_W +: WORD_W];
				word_in_valid = 1'b1;
				@(negedge clk);
			end
		end
		for (int p = 0; p < partial; p++) begin
			word_in = linegen_pkg::word_t'($urandom); // Never completes a line
			word_in_valid = 1'b1;
			@(negedge clk);
		end
		word_in_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_valid(output bit ok);
		int waited;
		waited = 0;
		while (!word_valid && waited < FILL_WAIT) begin
			@(negedge clk);
			waited++;
		end
		ok = word_valid;
	endtask

	task automatic take_word(input int row, input int pos, input int n);
		linegen_pkg::word_t expected;
		bit ok;
		expected = model[(pos / WORDS) % n][(pos % WORDS) * WORD_W +: WORD_W];
		repeat ($urandom % 3) @(negedge clk); // Consumer stall
		wait_valid(ok);
		checks++;
		if (!ok) begin
			$display("Row %0d word %0d: word_valid never rose", row, pos);
			row_errors++;
		end else begin
			if (word_out !== expected) begin
				$display("Mismatch word_out row %0d word %0d: expected %h, got %h",
					row, pos, expected, word_out);
				row_errors++;
			end
			word_take = 1'b1;
			@(negedge clk);
			word_take = 1'b0;
		end
	endtask

	task automatic restart_replay(input int row);
		replay_restart = 1'b1;
		@(negedge clk);
		replay_restart = 1'b0;
		checks++;
		if (word_valid !== 1'b0) begin
			$display("Mismatch word_valid row %0d after restart: expected 0, got %h",
				row, word_valid);
			row_errors++;
		end
	endtask

	task automatic run_row(input int r);
		int pos;
		bit ok;
		linegen_pkg::bram_state_t expected_state;
		row_errors = 0;
		write_session(row_lines[r], row_partial[r]);
		generator_mode = 1'b1;
		@(negedge clk);
		word_in = linegen_pkg::word_t'($urandom); // Ignored while write_rdy is low
		word_in_valid = 1'b1;
		wait_valid(ok);
		expected_state = row_gen[r] ? linegen_pkg::GENERATOR_MODE : linegen_pkg::SIMPLE_MODE;
		checks++;
		if (!ok) begin
			$display("Row %0d: word_valid never rose after generator_mode", r);
			row_errors++;
		end else if (dut0.u_bram_interface.bram_state !== expected_state) begin
			$display("Mismatch bram_state row %0d: expected %h, got %h",
				r, expected_state, dut0.u_bram_interface.bram_state);
			row_errors++;
		end
		pos = 0;
		for (int k = 0; k < row_words[r]; k++) begin
			if (k == row_restart[r]) begin
				restart_replay(r);
				pos = 0; // Replay starts over at line 0
			end
			take_word(r, pos, row_lines[r]);
			pos++;
		end
		if (row_drop[r] != 0) begin
			generator_mode = 1'b0;
			word_in_valid = 1'b0;
			@(negedge clk);
			checks += 2;
			if (write_rdy !== 1'b1) begin
				$display("Mismatch write_rdy row %0d after drop: expected 1, got %h",
					r, write_rdy);
				row_errors++;
			end
			if (word_valid !== 1'b0) begin
				$display("Mismatch word_valid row %0d after drop: expected 0, got %h",
					r, word_valid);
				row_errors++;
			end
		end
		$display("Row %0d: %0d lines, %0d words, %0d errors",
			r, row_lines[r], row_words[r], row_errors);
		errors += row_errors;
	endtask

	initial begin
		clk = 1'b0;
		rst_gen_mode = 1'b1;
		word_in = '0;
		word_in_valid = 1'b0;
		generator_mode = 1'b0;
		replay_restart = 1'b0;
		word_take = 1'b0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		void'($urandom(32'hd9cf_ede8));
		cycle_limit = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += 2 * (row_lines[r] * WORDS + row_partial[r] + 3 * row_words[r] + 20);
		end
		repeat (5) @(negedge clk);
		rst_gen_mode = 1'b0;
		checks += 2;
		if (write_rdy !== 1'b1) begin
			$display("Mismatch write_rdy after reset: expected 1, got %h", write_rdy);
			errors++;
		end
		if (word_valid !== 1'b0) begin
			$display("Mismatch word_valid after reset: expected 0, got %h", word_valid);
			errors++;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("Rows: %0d, checks: %0d, errors: %0d", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module linegen_tb -f vlog.f -o linegen_sim \
	&& ./obj_dir/linegen_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && exit 0 || exit 1

//--- verilog/bram_interface.sv
`include "linegen_config.svh"

module bram_interface (
	input  logic               clk,
	input  logic               rst_gen_mode,
	input  logic               replay_restart,
	input  logic               generator_mode,
	input  logic               we,
	input  logic               next,
	input  linegen_pkg::line_t line_out_raw,
	output linegen_pkg::addr_t buff_addr,
	output linegen_pkg::line_t line_out,
	output logic               valid_line_out,
	output logic               write_rdy
);

	localparam int BRAM_DELAY = `LINEGEN_BRAM_DELAY;
	localparam int BUFF_LEN = BRAM_DELAY + 1;
	localparam int PTR_W = $clog2(BUFF_LEN);

	linegen_pkg::bram_state_t bram_state;
	linegen_pkg::addr_t lines_stored;
	linegen_pkg::line_t line_buff [BUFF_LEN];
	logic [PTR_W-1:0] buff_place_ptr;
	logic [PTR_W-1:0] buff_access_ptr;
	logic [PTR_W-1:0] els_in_buff;
	logic fetch;                     // buff_addr is being read this cycle
	logic [BRAM_DELAY-1:0] valid_pipe;
	logic valid_line;
	logic buf_wr;
	logic pipe_empty;
	logic replaying;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(BUFF_LEN - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb begin
		valid_line = valid_pipe[BRAM_DELAY-1];
		pipe_empty = !fetch && (valid_pipe == '0);
		buf_wr = valid_line && (bram_state == linegen_pkg::FILL_BUFF ||
			bram_state == linegen_pkg::GENERATOR_MODE);
		replaying = bram_state == linegen_pkg::GENERATOR_MODE ||
			bram_state == linegen_pkg::SIMPLE_MODE;
		line_out = line_buff[buff_access_ptr];
		write_rdy = bram_state == linegen_pkg::WRITE_MODE;
	end

	// Tracks reads in flight through the memory latency
	always_ff @(posedge clk) begin
		if (rst_gen_mode) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[BRAM_DELAY-2:0], fetch};
		end
	end

	always_ff @(posedge clk) begin
		if (buf_wr) begin
			line_buff[buff_place_ptr] <= line_out_raw;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen_mode) begin
			bram_state <= linegen_pkg::WRITE_MODE;
			lines_stored <= '0;
			buff_addr <= '0;
			buff_place_ptr <= '0;
			buff_access_ptr <= '0;
			els_in_buff <= '0;
			fetch <= 1'b0;
			valid_line_out <= 1'b0;
		end else if (replaying && replay_restart) begin
			valid_line_out <= 1'b0;
			fetch <= 1'b0;
			bram_state <= linegen_pkg::PREP_GEN_MODE;
		end else if (replaying && !generator_mode) begin
			valid_line_out <= 1'b0;
			fetch <= 1'b0;
			lines_stored <= '0; // New write session starts at line 0
			bram_state <= linegen_pkg::WRITE_MODE;
		end else begin
			case (bram_state)
				linegen_pkg::WRITE_MODE: begin
					if (we) begin
						lines_stored <= lines_stored + 1'b1;
					end
					if (generator_mode) begin
						bram_state <= linegen_pkg::PREP_GEN_MODE;
					end
				end

				linegen_pkg::PREP_GEN_MODE: begin
					// Stale reads must drain before the buffer refills
					if (!replay_restart && pipe_empty) begin
						buff_addr <= '0;
						buff_place_ptr <= '0;
						buff_access_ptr <= '0;
						els_in_buff <= '0;
						fetch <= 1'b1;
						bram_state <= linegen_pkg::FILL_BUFF;
					end
				end

				linegen_pkg::FILL_BUFF: begin
					if (buff_addr < linegen_pkg::addr_t'(BUFF_LEN - 1)) begin
						buff_addr <= buff_addr + 1'b1;
					end else begin
						fetch <= 1'b0; // Lines 0 to BUFF_LEN-1 requested
					end
					if (buf_wr) begin
						els_in_buff <= els_in_buff + 1'b1;
						buff_place_ptr <= ptr_inc(buff_place_ptr);
					end
					if (els_in_buff == PTR_W'(BUFF_LEN)) begin
						valid_line_out <= 1'b1;
						bram_state <= (lines_stored > linegen_pkg::addr_t'(BUFF_LEN)) ?
							linegen_pkg::GENERATOR_MODE : linegen_pkg::SIMPLE_MODE;
					end
				end

				linegen_pkg::GENERATOR_MODE: begin
					fetch <= next; // One refill per consumed line
					if (next) begin
						buff_access_ptr <= ptr_inc(buff_access_ptr);
						buff_addr <= (buff_addr == lines_stored - 1'b1) ? '0 : buff_addr + 1'b1;
					end
					if (buf_wr && !next) begin
						els_in_buff <= els_in_buff + 1'b1;
					end else if (next && !buf_wr) begin
						els_in_buff <= els_in_buff - 1'b1;
					end
					if (buf_wr) begin
						buff_place_ptr <= ptr_inc(buff_place_ptr);
					end
				end

				linegen_pkg::SIMPLE_MODE: begin
					// Whole sequence sits in the buffer
					if (next) begin
						buff_access_ptr <= (buff_access_ptr == lines_stored - 1'b1) ?
							'0 : buff_access_ptr + 1'b1;
					end
				end

				default: begin
					bram_state <= linegen_pkg::WRITE_MODE;
				end
			endcase
		end
	end

endmodule

//--- verilog/line_assembler.sv
`include "linegen_config.svh"

module line_assembler (
	input  logic               clk,
	input  logic               rst_gen_mode,
	input  linegen_pkg::word_t word_in,
	input  logic               word_in_valid,
	input  logic               write_rdy,
	output logic               we,
	output linegen_pkg::addr_t waddr,
	output linegen_pkg::line_t wdata
);

	localparam linegen_pkg::word_idx_t LAST_WORD =
		linegen_pkg::word_idx_t'(linegen_pkg::WORDS_PER_LINE - 1);
	localparam linegen_pkg::addr_t DEPTH = linegen_pkg::addr_t'(`LINEGEN_BRAM_DEPTH);

	linegen_pkg::word_idx_t word_idx;
	logic accept;

	assign accept = word_in_valid && write_rdy;

	// Line builds up in place, low word first
	always_ff @(posedge clk) begin
		if (accept) begin
			wdata[word_idx * `LINEGEN_WORD_WIDTH +: `LINEGEN_WORD_WIDTH] <= word_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen_mode || !write_rdy) begin
			word_idx <= '0; // Partial line dropped
			waddr <= '0;
			we <= 1'b0;
		end else begin
			// Full memory swallows further lines
			we <= accept && (word_idx == LAST_WORD) && (waddr < DEPTH);
			if (we) begin
				waddr <= waddr + 1'b1;
			end
			if (accept) begin
				word_idx <= (word_idx == LAST_WORD) ? '0 : word_idx + 1'b1;
			end
		end
	end

endmodule

//--- verilog/line_bram.sv
`include "linegen_config.svh"

module line_bram (
	input  logic               clk,
	input  logic               we,
	input  linegen_pkg::addr_t waddr,
	input  linegen_pkg::line_t wdata,
	input  linegen_pkg::addr_t buff_addr,
	output linegen_pkg::line_t line_out_raw
);

	localparam int DEPTH = `LINEGEN_BRAM_DEPTH;
	localparam int DELAY = `LINEGEN_BRAM_DELAY;

	linegen_pkg::line_t mem [DEPTH];
	linegen_pkg::line_t rd_pipe [DELAY]; // Stage 0 is the read register

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		rd_pipe[0] <= mem[buff_addr];
		for (int i = 1; i < DELAY; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	assign line_out_raw = rd_pipe[DELAY-1];

endmodule

//--- verilog/linegen_config.svh
`ifndef LINEGEN_CONFIG_SVH
`define LINEGEN_CONFIG_SVH

// Line geometry. The line width must be a whole number of words
`define LINEGEN_DATA_WIDTH 48 // Bits per stored line
`define LINEGEN_WORD_WIDTH 16 // Bits per host / consumer word

// Line memory
`define LINEGEN_BRAM_DEPTH 600 // Lines held
`define LINEGEN_BRAM_DELAY 4   // Read latency in cycles

`endif

//--- verilog/linegen_pkg.sv
`include "linegen_config.svh"

package linegen_pkg;

	localparam int WORDS_PER_LINE = `LINEGEN_DATA_WIDTH / `LINEGEN_WORD_WIDTH;
	localparam int ADDR_WIDTH = $clog2(`LINEGEN_BRAM_DEPTH);

	typedef logic [`LINEGEN_DATA_WIDTH-1:0] line_t;
	typedef logic [`LINEGEN_WORD_WIDTH-1:0] word_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t; // Line address or line count
	typedef logic [1:0] word_idx_t;         // Word slot within a line

	// Replay control in bram_interface
	typedef enum logic [2:0] {
		WRITE_MODE,
		PREP_GEN_MODE,
		FILL_BUFF,
		GENERATOR_MODE,
		SIMPLE_MODE
	} bram_state_t;

endpackage

//--- verilog/linegen_top.sv
module linegen_top (
	input  logic               clk,
	input  logic               rst_gen_mode,
	input  linegen_pkg::word_t word_in,
	input  logic               word_in_valid,
	input  logic               generator_mode,
	input  logic               replay_restart,
	input  logic               word_take,
	output linegen_pkg::word_t word_out,
	output logic               word_valid,
	output logic               write_rdy
);

	logic we;
	linegen_pkg::addr_t waddr;
	linegen_pkg::line_t wdata;
	linegen_pkg::addr_t buff_addr;
	linegen_pkg::line_t line_out_raw;
	linegen_pkg::line_t line_out;
	logic valid_line_out;
	logic next;

	line_assembler u_line_assembler (
		.clk           (clk),
		.rst_gen_mode  (rst_gen_mode),
		.word_in       (word_in),
		.word_in_valid (word_in_valid),
		.write_rdy     (write_rdy),
		.we            (we),
		.waddr         (waddr),
		.wdata         (wdata)
	);

	line_bram u_line_bram (
		.clk          (clk),
		.we           (we),
		.waddr        (waddr),
		.wdata        (wdata),
		.buff_addr    (buff_addr),
		.line_out_raw (line_out_raw)
	);

	bram_interface u_bram_interface (
		.clk            (clk),
		.rst_gen_mode   (rst_gen_mode),
		.replay_restart (replay_restart),
		.generator_mode (generator_mode),
		.we             (we),
		.next           (next),
		.line_out_raw   (line_out_raw),
		.buff_addr      (buff_addr),
		.line_out       (line_out),
		.valid_line_out (valid_line_out),
		.write_rdy      (write_rdy)
	);

	word_serializer u_word_serializer (
		.clk            (clk),
		.rst_gen_mode   (rst_gen_mode),
		.line_out       (line_out),
		.valid_line_out (valid_line_out),
		.word_take      (word_take),
		.word_out       (word_out),
		.word_valid     (word_valid),
		.next           (next)
	);

endmodule

//--- verilog/word_serializer.sv
`include "linegen_config.svh"

module word_serializer (
	input  logic               clk,
	input  logic               rst_gen_mode,
	input  linegen_pkg::line_t line_out,
	input  logic               valid_line_out,
	input  logic               word_take,
	output linegen_pkg::word_t word_out,
	output logic               word_valid,
	output logic               next
);

	localparam linegen_pkg::word_idx_t LAST_WORD =
		linegen_pkg::word_idx_t'(linegen_pkg::WORDS_PER_LINE - 1);

	linegen_pkg::word_idx_t word_idx;
	logic consume;

	assign word_valid = valid_line_out;
	assign word_out = line_out[word_idx * `LINEGEN_WORD_WIDTH +: `LINEGEN_WORD_WIDTH];
	assign consume = word_valid && word_take;
	assign next = consume && (word_idx == LAST_WORD); // Last word of the line leaves

	always_ff @(posedge clk) begin
		if (rst_gen_mode || !valid_line_out) begin
			word_idx <= '0;
		end else if (consume) begin
			word_idx <= (word_idx == LAST_WORD) ? '0 : word_idx + 1'b1;
		end
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/linegen_pkg.sv
verilog/line_assembler.sv
verilog/line_bram.sv
verilog/bram_interface.sv
verilog/word_serializer.sv
verilog/linegen_top.sv
dv/linegen_checker.sv
dv/linegen_tb.sv
